//--- hdl/conv_pkg.sv
package conv_pkg;

    // window_t is sized for the largest kernel the layer is built for
    localparam int KERNEL_SIZE_MAX = 3;
    localparam int WINDOW_LEN      = KERNEL_SIZE_MAX * KERNEL_SIZE_MAX;

    typedef logic signed [15:0] pixel_t;
    typedef logic signed [31:0] psum_t;

    // row-major, entry r*KERNEL_SIZE+c
    typedef pixel_t window_t [WINDOW_LEN];

    // pixels held so that the newest and oldest span one full window
    function automatic int fifo_size(int ifm_size, int kernel_size);
        return (kernel_size - 1) * ifm_size + kernel_size;
    endfunction

    // valid convolution, no padding, stride one
    function automatic int out_size(int ifm_size, int kernel_size);
        return ifm_size - kernel_size + 1;
    endfunction

endpackage

//--- hdl/conv_ctrl_if.sv
`timescale 1ns/1ps

interface conv_ctrl_if #(
    parameter int KERNEL_SIZE = 3
);

    logic                                       shift_enable;
    logic                                       conv_enable;
    logic                                       weight_load;
    logic [$clog2(KERNEL_SIZE*KERNEL_SIZE)-1:0] weight_index;
    logic                                       accu_enable;
    logic                                       relu_enable;
    logic                                       write_enable;

    modport ctrl (
        output shift_enable,
        output conv_enable,
        output weight_load,
        output weight_index,
        output accu_enable,
        output relu_enable,
        output write_enable
    );

    modport dp (
        input conv_enable,
        input weight_load,
        input weight_index,
        input accu_enable,
        input relu_enable,
        input write_enable
    );

endinterface

//--- hdl/delay_line.sv
`timescale 1ns/1ps

module delay_line #(
    parameter type T     = logic,
    parameter int  DEPTH = 1
) (
    input  logic clk,
    input  logic reset,
    input  T     data_in,
    output T     data_out
);

    T stages [DEPTH];

    always_ff @(posedge clk or posedge reset)
    begin
        if (reset)
        begin
            for (int i = 0; i < DEPTH; i++)
                stages[i] <= '0;
        end
        else
        begin
            stages[0] <= data_in;
            for (int i = 1; i < DEPTH; i++)
                stages[i] <= stages[i-1];
        end
    end

    assign data_out = stages[DEPTH-1];

endmodule

//--- hdl/line_window.sv
`timescale 1ns/1ps

module line_window #(
    parameter int IFM_SIZE    = 5,
    parameter int KERNEL_SIZE = 3
) (
    input  logic              clk,
    input  logic              reset,
    input  logic              shift_enable,
    input  conv_pkg::pixel_t  pixel,
    output conv_pkg::window_t window
);
    import conv_pkg::*;

    localparam int FIFO_LEN = fifo_size(IFM_SIZE, KERNEL_SIZE);

    // taps[0] newest, taps[FIFO_LEN-1] oldest
    pixel_t taps [FIFO_LEN];

    always_ff @(posedge clk or posedge reset)
    begin
        if (reset)
        begin
            for (int i = 0; i < FIFO_LEN; i++)
                taps[i] <= '0;
        end
        else if (shift_enable)
        begin
            taps[0] <= pixel;
            for (int i = 1; i < FIFO_LEN; i++)
                taps[i] <= taps[i-1];
        end
    end

    // oldest tap is the top left of the window, kernel rows sit IFM_SIZE apart
    always_comb
    begin
        for (int w = 0; w < WINDOW_LEN; w++)
            window[w] = '0;
        for (int r = 0; r < KERNEL_SIZE; r++)
        begin
            for (int c = 0; c < KERNEL_SIZE; c++)
                window[r * KERNEL_SIZE + c] = taps[FIFO_LEN - 1 - r * IFM_SIZE - c];
        end
    end

endmodule

//--- hdl/conv_datapath.sv
`timescale 1ns/1ps

module conv_datapath #(
    parameter int KERNEL_SIZE = 3
) (
    input  logic              clk,
    input  logic              reset,
    conv_ctrl_if.dp           dp,
    input  conv_pkg::pixel_t  wm_data,
    input  conv_pkg::psum_t   bm_data,
    input  conv_pkg::window_t window,
    input  conv_pkg::psum_t   next_read_data,
    output conv_pkg::psum_t   next_write_data
);
    import conv_pkg::*;

    localparam int KK = KERNEL_SIZE * KERNEL_SIZE;

    window_t kernel;
    psum_t   bias_pending;
    psum_t   bias;
    psum_t   dot;
    psum_t   dot_reg;
    psum_t   sum;
    psum_t   result;

    always_ff @(posedge clk)
    begin
        if (dp.weight_load)
        begin
            kernel[dp.weight_index] <= wm_data;
            if (dp.weight_index == 0)
                bias_pending <= bm_data;
            // tail of the previous pass still uses the old bias until here
            if (dp.weight_index == KK - 1)
                bias <= bias_pending;
        end
    end

    always_comb
    begin
        dot = '0;
        for (int i = 0; i < KK; i++)
            dot += psum_t'(window[i]) * psum_t'(kernel[i]);
    end

    always_comb
    begin
        sum = dot_reg;
        if (dp.accu_enable)
            sum += next_read_data;
        if (dp.relu_enable)
            sum += bias;
    end

    // stage 1 product, stage 2 partial sum, bias and clamp
    always_ff @(posedge clk or posedge reset)
    begin
        if (reset)
        begin
            dot_reg <= '0;
            result  <= '0;
        end
        else
        begin
            if (dp.conv_enable)
                dot_reg <= dot;
            result <= (dp.relu_enable && sum < 0) ? '0 : sum;
        end
    end

    assign next_write_data = dp.write_enable ? result : '0;

endmodule

//--- hdl/conv_control.sv
`timescale 1ns/1ps

module conv_control #(
    parameter int IFM_SIZE          = 5,
    parameter int IFM_DEPTH         = 2,
    parameter int KERNEL_SIZE       = 3,
    parameter int NUMBER_OF_FILTERS = 2
) (
    input  logic clk,
    input  logic reset,
    input  logic start_from_previous,
    input  logic end_from_next,
    output logic end_to_previous,
    output logic ready,
    output logic start_to_next,
    output logic ifm_enable_read,
    output logic [$clog2(IFM_SIZE*IFM_SIZE)-1:0] ifm_address,
    output logic wm_enable_read,
    output logic [$clog2(KERNEL_SIZE*KERNEL_SIZE*IFM_DEPTH*NUMBER_OF_FILTERS)-1:0] wm_address,
    output logic bm_enable_read,
    output logic [$clog2(NUMBER_OF_FILTERS)-1:0] bm_address,
    output logic next_enable_read,
    output logic [$clog2(conv_pkg::out_size(IFM_SIZE, KERNEL_SIZE)**2)-1:0]
        next_read_address,
    output logic [$clog2(conv_pkg::out_size(IFM_SIZE, KERNEL_SIZE)**2)-1:0]
        next_write_address,
    conv_ctrl_if.ctrl ctrl
);
    import conv_pkg::*;

    localparam int PIXELS        = IFM_SIZE * IFM_SIZE;
    localparam int KK            = KERNEL_SIZE * KERNEL_SIZE;
    localparam int FIFO_LEN      = fifo_size(IFM_SIZE, KERNEL_SIZE);
    localparam int OUT           = out_size(IFM_SIZE, KERNEL_SIZE);
    localparam int WM_W          = $clog2(KK * IFM_DEPTH * NUMBER_OF_FILTERS);
    localparam int NEXT_W        = $clog2(OUT * OUT);
    localparam int KK_W          = $clog2(KK);
    localparam int FILL_W        = $clog2(FIFO_LEN);
    localparam int SPAN_W        = $clog2(OUT + KERNEL_SIZE);
    localparam int ROW_W         = $clog2(OUT + 1);
    localparam int WRITE_LATENCY = 2;

    typedef enum logic [1:0] {IDLE, READ, FINISH} main_state_t;
    typedef enum logic [1:0] {W_FILL, W_VALID, W_INVALID} win_state_t;
    typedef enum logic {H_IDLE, H_HOLD} hand_state_t;
    typedef logic [NEXT_W-1:0] next_addr_t;

    main_state_t                      state;
    win_state_t                       wstate;
    hand_state_t                      hstate;
    logic [$clog2(IFM_DEPTH)-1:0]     channel_count;
    logic [$clog2(NUMBER_OF_FILTERS)-1:0] filter_count;
    logic                             start;
    logic                             pass_end;
    logic                             last_pass;
    logic                             last_write;
    logic                             shift_enable;
    logic                             conv_enable;
    logic                             write_enable;
    logic                             weight_load;
    logic [KK_W-1:0]                  weight_index;
    logic                             accu_flag;
    logic                             relu_flag;
    logic [FILL_W-1:0]                fill_count;
    logic [SPAN_W-1:0]                span_count;
    logic [ROW_W-1:0]                 row_count;

    assign start      = start_from_previous && ready && end_to_previous;
    assign pass_end   = (state == READ) && (ifm_address == PIXELS - 1);
    assign last_pass  = (channel_count == IFM_DEPTH - 1) &&
                        (filter_count == NUMBER_OF_FILTERS - 1);
    assign last_write = (state == FINISH) && write_enable &&
                        (next_write_address == OUT * OUT - 1);

    // passes run back to back, the next one starts right after the last address
    always_ff @(posedge clk or posedge reset)
    begin
        if (reset)
        begin
            state         <= IDLE;
            ifm_address   <= '0;
            channel_count <= '0;
            filter_count  <= '0;
        end
        else
        begin
            case (state)
                IDLE:
                    if (start)
                        state <= READ;
                READ:
                begin
                    if (pass_end)
                    begin
                        ifm_address <= '0;
                        if (channel_count == IFM_DEPTH - 1)
                        begin
                            channel_count <= '0;
                            if (filter_count == NUMBER_OF_FILTERS - 1)
                                filter_count <= '0;
                            else
                                filter_count <= filter_count + 1'b1;
                        end
                        else
                            channel_count <= channel_count + 1'b1;
                        if (last_pass)
                            state <= FINISH;
                    end
                    else
                        ifm_address <= ifm_address + 1'b1;
                end
                FINISH:
                    if (last_write)
                        state <= IDLE;
                default:
                    state <= IDLE;
            endcase
        end
    end

    assign ifm_enable_read = (state == READ);
    assign wm_enable_read  = (state == READ) && (ifm_address < KK);
    assign wm_address      = WM_W'((filter_count * IFM_DEPTH + channel_count) * KK + ifm_address);
    assign bm_enable_read  = (state == READ) && (ifm_address == 0) &&
                             (channel_count == IFM_DEPTH - 1);
    assign bm_address      = filter_count;
    assign end_to_previous = (state != READ);
    assign ready           = (state == IDLE) && (hstate == H_IDLE);

    // memory data lands one cycle after the read
    always_ff @(posedge clk or posedge reset)
    begin
        if (reset)
        begin
            shift_enable <= 1'b0;
            weight_load  <= 1'b0;
            weight_index <= '0;
        end
        else
        begin
            shift_enable <= ifm_enable_read;
            weight_load  <= wm_enable_read;
            weight_index <= KK_W'(ifm_address);
        end
    end

    // window timing: fill, then valid and invalid spans per output row
    always_ff @(posedge clk or posedge reset)
    begin
        if (reset)
        begin
            wstate     <= W_FILL;
            fill_count <= '0;
            span_count <= '0;
            row_count  <= '0;
            accu_flag  <= 1'b0;
            relu_flag  <= 1'b0;
        end
        else
        begin
            case (wstate)
                W_FILL:
                    if (shift_enable)
                    begin
                        if (fill_count == FIFO_LEN - 1)
                        begin
                            wstate     <= W_VALID;
                            fill_count <= '0;
                            accu_flag  <= (channel_count != 0);
                            relu_flag  <= (channel_count == IFM_DEPTH - 1);
                        end
                        else
                            fill_count <= fill_count + 1'b1;
                    end
                W_VALID:
                    if (span_count == OUT - 1)
                    begin
                        span_count <= '0;
                        if (row_count == OUT - 1)
                        begin
                            wstate     <= W_FILL;
                            row_count  <= '0;
                            // first pixel of the next pass may already be going in
                            fill_count <= FILL_W'(shift_enable);
                        end
                        else
                            wstate <= W_INVALID;
                    end
                    else
                        span_count <= span_count + 1'b1;
                W_INVALID:
                    if (span_count == KERNEL_SIZE - 2)
                    begin
                        wstate     <= W_VALID;
                        span_count <= '0;
                        row_count  <= row_count + 1'b1;
                    end
                    else
                        span_count <= span_count + 1'b1;
                default:
                    wstate <= W_FILL;
            endcase
        end
    end

    assign conv_enable      = (wstate == W_VALID);
    assign next_enable_read = conv_enable;

    always_ff @(posedge clk or posedge reset)
    begin
        if (reset)
            next_read_address <= '0;
        else if (conv_enable)
            next_read_address <= (next_read_address == OUT * OUT - 1) ?
                                 '0 : next_read_address + 1'b1;
    end

    // product stage plus accumulate stage
    delay_line #(.T(logic), .DEPTH(WRITE_LATENCY)) write_enable_delay (
        .clk      (clk),
        .reset    (reset),
        .data_in  (conv_enable),
        .data_out (write_enable)
    );

    delay_line #(.T(next_addr_t), .DEPTH(WRITE_LATENCY)) write_address_delay (
        .clk      (clk),
        .reset    (reset),
        .data_in  (next_read_address),
        .data_out (next_write_address)
    );

    // handoff waits for the next layer to be free
    always_ff @(posedge clk or posedge reset)
    begin
        if (reset)
            hstate <= H_IDLE;
        else
        begin
            case (hstate)
                H_IDLE:
                    if (last_write)
                        hstate <= H_HOLD;
                H_HOLD:
                    if (end_from_next)
                        hstate <= H_IDLE;
                default:
                    hstate <= H_IDLE;
            endcase
        end
    end

    assign start_to_next = (hstate == H_HOLD) && end_from_next;

    assign ctrl.shift_enable = shift_enable;
    assign ctrl.conv_enable  = conv_enable;
    assign ctrl.weight_load  = weight_load;
    assign ctrl.weight_index = weight_index;
    assign ctrl.accu_enable  = accu_flag;
    assign ctrl.relu_enable  = relu_flag;
    assign ctrl.write_enable = write_enable;

endmodule

//--- hdl/conv_layer.sv
`timescale 1ns/1ps

module conv_layer #(
    parameter int IFM_SIZE          = 5,
    parameter int IFM_DEPTH         = 2,
    parameter int KERNEL_SIZE       = 3,
    parameter int NUMBER_OF_FILTERS = 2
) (
    input  logic             clk,
    input  logic             reset,
    input  logic             start_from_previous,
    output logic             end_to_previous,
    output logic             ready,
    input  logic             end_from_next,
    output logic             start_to_next,
    output logic             ifm_enable_read,
    output logic [$clog2(IFM_SIZE*IFM_SIZE)-1:0] ifm_address,
    input  conv_pkg::pixel_t ifm_data,
    output logic             wm_enable_read,
    output logic [$clog2(KERNEL_SIZE*KERNEL_SIZE*IFM_DEPTH*NUMBER_OF_FILTERS)-1:0] wm_address,
    input  conv_pkg::pixel_t wm_data,
    output logic             bm_enable_read,
    output logic [$clog2(NUMBER_OF_FILTERS)-1:0] bm_address,
    input  conv_pkg::psum_t  bm_data,
    output logic             next_enable_read,
    output logic [$clog2(conv_pkg::out_size(IFM_SIZE, KERNEL_SIZE)**2)-1:0]
        next_read_address,
    input  conv_pkg::psum_t  next_read_data,
    output logic             next_enable_write,
    output logic [$clog2(conv_pkg::out_size(IFM_SIZE, KERNEL_SIZE)**2)-1:0]
        next_write_address,
    output conv_pkg::psum_t  next_write_data
);
    import conv_pkg::*;

    window_t window;

    conv_ctrl_if #(.KERNEL_SIZE(KERNEL_SIZE)) ctrl_bus ();

    conv_control #(
        .IFM_SIZE          (IFM_SIZE),
        .IFM_DEPTH         (IFM_DEPTH),
        .KERNEL_SIZE       (KERNEL_SIZE),
        .NUMBER_OF_FILTERS (NUMBER_OF_FILTERS)
    ) control (
        .clk                 (clk),
        .reset               (reset),
        .start_from_previous (start_from_previous),
        .end_from_next       (end_from_next),
        .end_to_previous     (end_to_previous),
        .ready               (ready),
        .start_to_next       (start_to_next),
        .ifm_enable_read     (ifm_enable_read),
        .ifm_address         (ifm_address),
        .wm_enable_read      (wm_enable_read),
        .wm_address          (wm_address),
        .bm_enable_read      (bm_enable_read),
        .bm_address          (bm_address),
        .next_enable_read    (next_enable_read),
        .next_read_address   (next_read_address),
        .next_write_address  (next_write_address),
        .ctrl                (ctrl_bus)
    );

    line_window #(
        .IFM_SIZE    (IFM_SIZE),
        .KERNEL_SIZE (KERNEL_SIZE)
    ) window_unit (
        .clk          (clk),
        .reset        (reset),
        .shift_enable (ctrl_bus.shift_enable),
        .pixel        (ifm_data),
        .window       (window)
    );

    conv_datapath #(.KERNEL_SIZE(KERNEL_SIZE)) datapath (
        .clk             (clk),
        .reset           (reset),
        .dp              (ctrl_bus),
        .wm_data         (wm_data),
        .bm_data         (bm_data),
        .window          (window),
        .next_read_data  (next_read_data),
        .next_write_data (next_write_data)
    );

    assign next_enable_write = ctrl_bus.write_enable;

endmodule

//--- verif/conv_layer_sva.sv
`timescale 1ns/1ps

module conv_layer_sva #(
    parameter int IFM_SIZE    = 5,
    parameter int KERNEL_SIZE = 3
) (
    input logic clk,
    input logic reset,
    input logic ready,
    input logic end_to_previous,
    input logic start_to_next,
    input logic end_from_next,
    input logic ifm_enable_read,
    input logic [$clog2(IFM_SIZE*IFM_SIZE)-1:0] ifm_address,
    input logic wm_enable_read,
    input logic bm_enable_read,
    input logic next_enable_read,
    input logic [$clog2(conv_pkg::out_size(IFM_SIZE, KERNEL_SIZE)**2)-1:0] next_read_address,
    input logic next_enable_write,
    input logic [$clog2(conv_pkg::out_size(IFM_SIZE, KERNEL_SIZE)**2)-1:0] next_write_address
);

    localparam int PIXELS = IFM_SIZE * IFM_SIZE;
    localparam int KK     = KERNEL_SIZE * KERNEL_SIZE;

    int failures = 0;

    a_reset_values: assert property (@(posedge clk)
        reset |-> !ifm_enable_read && !wm_enable_read && !bm_enable_read &&
                  !next_enable_read && !next_enable_write && !start_to_next &&
                  ready && end_to_previous)
    else
    begin
        $error("outputs are not at their reset values");
        failures++;
    end

    // a pass always opens at pixel 0
    a_ifm_first: assert property (@(posedge clk) disable iff (reset)
        ifm_enable_read && (!$past(ifm_enable_read) || $past(ifm_address) == PIXELS - 1)
            |-> ifm_address == 0)
    else
    begin
        $error("IFM read sequence does not start at address 0");
        failures++;
    end

    a_ifm_step: assert property (@(posedge clk) disable iff (reset)
        ifm_enable_read && ifm_address != PIXELS - 1 |=>
            ifm_enable_read && ifm_address == $past(ifm_address) + 1)
    else
    begin
        $error("IFM addresses are not consecutive");
        failures++;
    end

    a_weight_reads: assert property (@(posedge clk) disable iff (reset)
        wm_enable_read == (ifm_enable_read && ifm_address < KK))
    else
    begin
        $error("weight reads are not the first kernel cycles of the pass");
        failures++;
    end

    a_bias_read: assert property (@(posedge clk) disable iff (reset)
        bm_enable_read |-> ifm_enable_read && ifm_address == 0)
    else
    begin
        $error("bias read outside the first cycle of a pass");
        failures++;
    end

    a_write_follows_read: assert property (@(posedge clk) disable iff (reset)
        next_enable_read |-> ##2 (next_enable_write &&
                                  next_write_address == $past(next_read_address, 2)))
    else
    begin
        $error("write does not follow its partial sum read by two cycles");
        failures++;
    end

    a_write_has_read: assert property (@(posedge clk) disable iff (reset)
        next_enable_write |-> $past(next_enable_read, 2))
    else
    begin
        $error("write without a matching partial sum read");
        failures++;
    end

    a_busy_not_ready: assert property (@(posedge clk) disable iff (reset)
        ifm_enable_read |-> !ready)
    else
    begin
        $error("ready is high while a pass is reading");
        failures++;
    end

    a_start_needs_end: assert property (@(posedge clk) disable iff (reset)
        start_to_next |-> end_from_next)
    else
    begin
        $error("start_to_next raised while end_from_next is low");
        failures++;
    end

    a_start_pulse: assert property (@(posedge clk) disable iff (reset)
        start_to_next |=> !start_to_next)
    else
    begin
        $error("start_to_next is longer than one cycle");
        failures++;
    end

endmodule

bind conv_layer conv_layer_sva #(
    .IFM_SIZE    (IFM_SIZE),
    .KERNEL_SIZE (KERNEL_SIZE)
) sva_checks (.*);

//--- verif/conv_layer_tb.sv
`timescale 1ns/1ps

module conv_layer_tb;
    import conv_pkg::*;

    localparam int IFM_SIZE          = 5;
    localparam int IFM_DEPTH         = 2;
    localparam int KERNEL_SIZE       = 3;
    localparam int NUMBER_OF_FILTERS = 2;
    localparam int PIXELS            = IFM_SIZE * IFM_SIZE;
    localparam int KK                = KERNEL_SIZE * KERNEL_SIZE;
    localparam int OUT               = out_size(IFM_SIZE, KERNEL_SIZE);
    localparam int OUTPUTS           = OUT * OUT;
    localparam int PASSES            = IFM_DEPTH * NUMBER_OF_FILTERS;
    localparam int WEIGHTS           = KK * PASSES;
    localparam int TIMEOUT           = 1000;

    logic                                 clk;
    logic                                 reset;
    logic                                 start_from_previous;
    logic                                 end_to_previous;
    logic                                 ready;
    logic                                 end_from_next;
    logic                                 start_to_next;
    logic                                 ifm_enable_read;
    logic [$clog2(PIXELS)-1:0]            ifm_address;
    pixel_t                               ifm_data;
    logic                                 wm_enable_read;
    logic [$clog2(WEIGHTS)-1:0]           wm_address;
    pixel_t                               wm_data;
    logic                                 bm_enable_read;
    logic [$clog2(NUMBER_OF_FILTERS)-1:0] bm_address;
    psum_t                                bm_data;
    logic                                 next_enable_read;
    logic [$clog2(OUTPUTS)-1:0]           next_read_address;
    psum_t                                next_read_data;
    logic                                 next_enable_write;
    logic [$clog2(OUTPUTS)-1:0]           next_write_address;
    psum_t                                next_write_data;

    pixel_t ifm_mem [IFM_DEPTH][PIXELS];
    pixel_t wm_mem [WEIGHTS];
    psum_t  bm_mem [NUMBER_OF_FILTERS];
    psum_t  next_mem [OUTPUTS];
    psum_t  golden [NUMBER_OF_FILTERS][OUTPUTS];

    logic [31:0] rng;
    int          read_pass;
    int          write_pass;
    int          write_count;
    int          total_writes;
    int          handoffs;
    logic        check_pending;
    int          check_filter;
    int          hold_cycles;
    int          value_errors = 0;
    int          other_errors = 0;

    conv_layer uut (.*);

    initial clk = 1'b0;
    always #4 clk = ~clk;

    function automatic logic [31:0] xorshift(logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    function automatic int random_in(int low, int span);
        rng = xorshift(rng);
        return low + int'(rng % span);
    endfunction

    task automatic report_mismatch(string test, int expected, int actual);
        value_errors++;
        $display("ERROR %s: expected %0d, actual %0d", test, expected, actual);
    endtask

    task automatic report_failure(string what);
        other_errors++;
        $display("FAILURE: %s", what);
    endtask

    // small signed ranges keep the sums readable
    task automatic fill_memories();
        for (int ch = 0; ch < IFM_DEPTH; ch++)
            for (int p = 0; p < PIXELS; p++)
                ifm_mem[ch][p] = pixel_t'(random_in(-8, 16));
        for (int w = 0; w < WEIGHTS; w++)
            wm_mem[w] = pixel_t'(random_in(-4, 8));
        for (int f = 0; f < NUMBER_OF_FILTERS; f++)
            bm_mem[f] = psum_t'(random_in(-40, 80));
        for (int a = 0; a < OUTPUTS; a++)
            next_mem[a] <= psum_t'(random_in(-1000, 2000));
    endtask

    task automatic compute_golden();
        psum_t acc;
        for (int f = 0; f < NUMBER_OF_FILTERS; f++)
        begin
            for (int orow = 0; orow < OUT; orow++)
            begin
                for (int ocol = 0; ocol < OUT; ocol++)
                begin
                    acc = bm_mem[f];
                    for (int ch = 0; ch < IFM_DEPTH; ch++)
                        for (int r = 0; r < KERNEL_SIZE; r++)
                            for (int c = 0; c < KERNEL_SIZE; c++)
                                acc += psum_t'(ifm_mem[ch][(orow + r) * IFM_SIZE + ocol + c]) *
                                       psum_t'(wm_mem[(f * IFM_DEPTH + ch) * KK +
                                                      r * KERNEL_SIZE + c]);
                    golden[f][orow * OUT + ocol] = (acc < 0) ? psum_t'(0) : acc;
                end
            end
        end
    endtask

    task automatic check_outputs(int f);
        for (int a = 0; a < OUTPUTS; a++)
            assert (next_mem[a] === golden[f][a])
            else report_mismatch($sformatf("output_f%0d_p%0d", f, a), golden[f][a], next_mem[a]);
    endtask

    task automatic wait_ready();
        int cycles;
        cycles = 0;
        do
        begin
            @(negedge clk);
            cycles++;
        end
        while (!ready && cycles < TIMEOUT);
        if (!ready)
            report_failure("timed out waiting for ready");
    endtask

    task automatic wait_passes(int target);
        int cycles;
        cycles = 0;
        do
        begin
            @(negedge clk);
            cycles++;
        end
        while (read_pass < target && cycles < TIMEOUT);
        if (read_pass < target)
            report_failure("timed out waiting for IFM passes");
    endtask

    task automatic wait_writes(int target);
        int cycles;
        cycles = 0;
        do
        begin
            @(negedge clk);
            cycles++;
        end
        while (total_writes < target && cycles < TIMEOUT);
        if (total_writes < target)
            report_failure("timed out waiting for the next-layer writes");
    endtask

    task automatic wait_handoff();
        int cycles;
        cycles = 0;
        do
        begin
            @(negedge clk);
            cycles++;
        end
        while (handoffs < 1 && cycles < TIMEOUT);
        if (handoffs < 1)
            report_failure("timed out waiting for start_to_next");
    endtask

    // external memories answer one cycle after the enable
    always @(posedge clk)
    begin
        if (ifm_enable_read)
            ifm_data <= ifm_mem[read_pass % IFM_DEPTH][ifm_address];
        if (wm_enable_read)
            wm_data <= wm_mem[wm_address];
        if (bm_enable_read)
            bm_data <= bm_mem[bm_address];
        if (next_enable_read)
            next_read_data <= next_mem[next_read_address];
        if (next_enable_write)
            next_mem[next_write_address] <= next_write_data;
    end

    always @(posedge clk)
    begin
        if (reset)
        begin
            read_pass     <= 0;
            write_pass    <= 0;
            write_count   <= 0;
            total_writes  <= 0;
            handoffs      <= 0;
            check_pending <= 1'b0;
            check_filter  <= 0;
        end
        else
        begin
            if (ifm_enable_read && ifm_address == PIXELS - 1)
                read_pass <= read_pass + 1;
            if (ifm_enable_read && ifm_address == 0 && read_pass > 0)
            begin
                assert (!ready) else report_failure("ready is high during a later pass");
            end
            // memory already holds the last write of the pass here
            if (check_pending)
            begin
                check_outputs(check_filter);
                check_pending <= 1'b0;
            end
            if (next_enable_write)
            begin
                assert (next_write_address == write_count)
                else report_mismatch("write_address", write_count, next_write_address);
                total_writes <= total_writes + 1;
                if (write_count == OUTPUTS - 1)
                begin
                    write_count   <= 0;
                    write_pass    <= write_pass + 1;
                    check_pending <= (write_pass % IFM_DEPTH == IFM_DEPTH - 1);
                    check_filter  <= write_pass / IFM_DEPTH;
                end
                else
                    write_count <= write_count + 1;
            end
            if (start_to_next)
            begin
                handoffs <= handoffs + 1;
                assert (total_writes == PASSES * OUTPUTS)
                else report_failure("start_to_next pulsed before the final write");
            end
        end
    end

    initial
    begin
        rng = 32'h504;
        reset               <= 1'b1;
        start_from_previous <= 1'b0;
        end_from_next       <= 1'b0;
        ifm_data            <= '0;
        wm_data             <= '0;
        bm_data             <= '0;
        next_read_data      <= '0;
        fill_memories();
        compute_golden();
        repeat (2) @(posedge clk);
        reset <= 1'b0;

        wait_ready();
        @(posedge clk);
        start_from_previous <= 1'b1;
        @(posedge clk);
        start_from_previous <= 1'b0;

        // a start while busy must not trigger another read sequence
        wait_passes(1);
        @(posedge clk);
        start_from_previous <= 1'b1;
        // next layer already free while the passes still run
        end_from_next       <= 1'b1;
        @(posedge clk);
        start_from_previous <= 1'b0;

        wait_passes(PASSES - 1);
        @(posedge clk);
        end_from_next <= 1'b0;

        wait_writes(PASSES * OUTPUTS);
        hold_cycles = random_in(3, 16);
        repeat (hold_cycles) @(posedge clk);
        end_from_next <= 1'b1;
        wait_handoff();
        @(posedge clk);
        end_from_next <= 1'b0;

        @(negedge clk);
        assert (read_pass == PASSES) else report_mismatch("pass_count", PASSES, read_pass);
        assert (handoffs == 1) else report_mismatch("handoff_count", 1, handoffs);
        $display("value errors: %0d, other errors: %0d, assertion failures: %0d",
                 value_errors, other_errors, uut.sva_checks.failures);
        if (value_errors + other_errors + uut.sva_checks.failures == 0)
            $display("Done: no errors");
        else
            $display("Done: errors found");
        $finish;
    end

endmodule

//--- conv_layer.f
hdl/conv_pkg.sv
hdl/conv_ctrl_if.sv
hdl/delay_line.sv
hdl/line_window.sv
hdl/conv_datapath.sv
hdl/conv_control.sv
hdl/conv_layer.sv
verif/conv_layer_sva.sv
verif/conv_layer_tb.sv
